//--- bench/tbRefModel.svh
// Reference model for the controller bench with instruction encoders and expected control words
`ifndef tbRefModelSvh
`define tbRefModelSvh

function automatic ctrlPkg::instrT encR(input logic [6:0] f7, input ctrlPkg::regAddrT rs2,
                                        input ctrlPkg::regAddrT rs1, input logic [2:0] f3,
                                        input ctrlPkg::regAddrT rd);
  return {f7, rs2, rs1, f3, rd, ctrlPkg::opOp};
endfunction

function automatic ctrlPkg::instrT encI(input logic [6:0] op, input ctrlPkg::regAddrT rs1,
                                        input logic [2:0] f3, input ctrlPkg::regAddrT rd);
  return {12'h004, rs1, f3, rd, op};        // Small fixed immediate
endfunction

// Low immediate bits sit where rd would be
function automatic ctrlPkg::instrT encS(input ctrlPkg::regAddrT rs2, input ctrlPkg::regAddrT rs1,
                                        input logic [2:0] f3, input logic [4:0] immLo);
  return {7'h00, rs2, rs1, f3, immLo, ctrlPkg::opStore};
endfunction

function automatic ctrlPkg::instrT encB(input ctrlPkg::regAddrT rs2, input ctrlPkg::regAddrT rs1,
                                        input logic [2:0] f3);
  return {7'h00, rs2, rs1, f3, 5'h08, ctrlPkg::opBranch};
endfunction

function automatic ctrlPkg::instrT encU(input logic [6:0] op, input ctrlPkg::regAddrT rd);
  return {20'h12345, rd, op};
endfunction

function automatic ctrlPkg::instrT encJ(input ctrlPkg::regAddrT rd);
  return {20'h00100, rd, ctrlPkg::opJal};
endfunction

function automatic ctrlPkg::instrT encCsr(input logic [2:0] f3, input ctrlPkg::regAddrT rs1,
                                          input ctrlPkg::regAddrT rd);
  return {12'h300, rs1, f3, rd, ctrlPkg::opSystem};  // mstatus
endfunction

// Expected decoder word for one instruction
function automatic ctrlPkg::ctrlWordT refCtrl(input ctrlPkg::instrT w);
  ctrlPkg::ctrlWordT c;
  logic [6:0] f7;
  logic [2:0] f3;
  logic ok;
  logic mul;
  logic csr;
  logic priv;
  c    = '0;
  ok   = 1'b0;
  f7   = w[31:25];
  f3   = w[14:12];
  mul  = (f7 == 7'h01);
  csr  = (f3[1:0] != 2'b00);
  priv = (f3 == 3'd0) && (w[11:7] == 5'd0);
  case (w[6:0])
    ctrlPkg::opLoad: begin
      ok = (f3 != 3'd3) && (f3 < 3'd6);       // lb lh lw lbu lhu
      c.regWrite = 1'b1;
      c.aluSrcB = 1'b1;
      c.memRW = 2'b10;
      c.resultSrc = ctrlPkg::resMem;
    end
    ctrlPkg::opFence: ok = (f3 == 3'd0);
    ctrlPkg::opOpImm: begin
      ok = (f3 == 3'd1) ? (f7 == 7'h00) :
           (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
      c.regWrite = 1'b1;
      c.aluSrcB = 1'b1;
      c.aluOp = 1'b1;
    end
    ctrlPkg::opAuipc, ctrlPkg::opLui: begin
      ok = 1'b1;
      c.regWrite = 1'b1;
      c.immSrc = ctrlPkg::immU;
      c.aluSrcA = (w[6:0] == ctrlPkg::opAuipc);  // PC plus upper immediate
      c.aluSrcB = 1'b1;
    end
    ctrlPkg::opStore: begin
      ok = (f3 < 3'd3);
      c.immSrc = ctrlPkg::immS;
      c.aluSrcB = 1'b1;
      c.memRW = 2'b01;
    end
    ctrlPkg::opOp: begin
      ok = (f7 == 7'h00) || mul || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      c.regWrite = 1'b1;
      c.aluOp = !mul;
      c.mdu = mul;
      c.resultSrc = mul ? ctrlPkg::resMdu : ctrlPkg::resAlu;
    end
    ctrlPkg::opBranch: begin
      ok = (f3 != 3'd2) && (f3 != 3'd3);
      c.immSrc = ctrlPkg::immB;
      c.aluSrcA = 1'b1;
      c.aluSrcB = 1'b1;
      c.branch = 1'b1;
    end
    ctrlPkg::opJalr: begin
      ok = (f3 == 3'd0);
      c.regWrite = 1'b1;
      c.aluSrcB = 1'b1;
      c.jump = 1'b1;
    end
    ctrlPkg::opJal: begin
      ok = 1'b1;
      c.regWrite = 1'b1;
      c.immSrc = ctrlPkg::immJ;
      c.aluSrcA = 1'b1;
      c.aluSrcB = 1'b1;
      c.jump = 1'b1;
    end
    ctrlPkg::opSystem: begin
      ok = priv || csr;
      c.regWrite = csr;
      c.csrRead = csr;
      c.privileged = priv;
      c.resultSrc = csr ? ctrlPkg::resCsr : ctrlPkg::resAlu;
    end
    default: ok = 1'b0;
  endcase
  return ok ? c : ctrlPkg::ctrlIllegal;
endfunction

// Sub, sra, slt and sltu forms of the ALU ops
function automatic logic refSubArith(input ctrlPkg::instrT w);
  ctrlPkg::ctrlWordT c;
  logic [2:0] f3;
  logic alt;
  c   = refCtrl(w);
  f3  = w[14:12];
  alt = (w[31:25] == 7'h20);
  return c.aluOp && ((f3 == 3'd0 && alt && w[6:0] == ctrlPkg::opOp) ||
                     (f3 == 3'd5 && alt) || f3 == 3'd2 || f3 == 3'd3);
endfunction

`endif

//--- bench/tbController.sv
// Testbench for the pipeline controller covering decode, pipelining, branches and hazards
module tbController;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int maxCycles = 2000;            // About 500 cycles of tests plus margin

  logic clk, rstN;
  logic stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW;
  ctrlPkg::instrT instrD;
  logic [1:0] flagsE;
  ctrlPkg::immSrcT immSrcD;
  logic illegalInstrD, jumpD, branchD;
  ctrlPkg::regAddrT rs1D, rs2D, rs2E, rdE, rdM, rdW;
  logic pcSrcE, aluSrcAE, aluSrcBE, subArithE, branchSignedE, intDivE, mduActiveE;
  logic [2:0] aluSelectE, funct3E, funct3M;
  logic [1:0] memRWE, memRWM;
  logic csrReadM, csrWriteM, privilegedM;
  logic instrValidD, instrValidE, instrValidM;
  logic regWriteW, intDivW;
  ctrlPkg::resultSrcT resultSrcW;
  ctrlPkg::fwdSelT forwardAE, forwardBE;
  logic loadStallD, storeStallD, structuralStallD;
  int cycles;

  `include "tbRefModel.svh"

  controller dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                    // 10 ns period
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= maxCycles) begin
      $display("Timeout: run exceeded %0d cycles", maxCycles);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  task automatic expectEq(input string name, input logic [31:0] expVal, input logic [31:0] actVal);
    assert (expVal === actVal) else begin
      $display("[FAIL] %s expected %0h actual %0h", name, expVal, actVal);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  // Drive a new Decode word just after the edge
  task automatic clockIn(input ctrlPkg::instrT w);
    @(posedge clk);
    #1 instrD = w;
  endtask

  function automatic ctrlPkg::regAddrT pickReg();
    return ctrlPkg::regAddrT'($urandom_range(31, 1));
  endfunction

  ctrlPkg::instrT hist[$];
  ctrlPkg::instrT w;
  ctrlPkg::ctrlWordT c;
  ctrlPkg::regAddrT r, r2;
  logic [2:0] f3;
  logic expTaken;

  initial begin
    void'($urandom(60037));
    cycles = 0;
    rstN = 1'b0;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    instrD = '0;
    flagsE = '0;
    repeat (4) @(posedge clk);
    #1;
    expectEq("reset validD", 0, instrValidD);
    expectEq("reset validE", 0, instrValidE);
    expectEq("reset validM", 0, instrValidM);
    expectEq("reset regWriteW", 0, regWriteW);
    expectEq("reset memRWM", 0, memRWM);
    expectEq("reset csrWriteM", 0, csrWriteM);
    expectEq("reset pcSrcE", 0, pcSrcE);
    expectEq("reset forwardAE", 0, forwardAE);
    expectEq("reset forwardBE", 0, forwardBE);
    rstN = 1'b1;

    ////////////////////////////// Decode
    for (int i = 0; i < 220; i++) begin
      w = $urandom;
      case (i % 11)                           // Kept opcode, random fields
        0: w[6:0] = ctrlPkg::opLoad;
        1: w[6:0] = ctrlPkg::opFence;
        2: w[6:0] = ctrlPkg::opOpImm;
        3: w[6:0] = ctrlPkg::opAuipc;
        4: w[6:0] = ctrlPkg::opStore;
        5: w[6:0] = ctrlPkg::opOp;
        6: w[6:0] = ctrlPkg::opLui;
        7: w[6:0] = ctrlPkg::opBranch;
        8: w[6:0] = ctrlPkg::opJalr;
        9: w[6:0] = ctrlPkg::opJal;
        default: w[6:0] = ctrlPkg::opSystem;
      endcase
      if (i == 0) w = encR(7'h40, 5'd2, 5'd1, 3'd0, 5'd3);       // Bad funct7
      if (i == 1) w = {17'h0, 3'd1, 5'd1, ctrlPkg::opJalr};      // jalr funct3 nonzero
      if (i == 2) w = {25'h0, 7'b1111111};                       // Unknown opcode
      clockIn(w);
      #1;
      c = refCtrl(w);
      expectEq("decode immSrc", c.immSrc, immSrcD);
      expectEq("decode jump", c.jump, jumpD);
      expectEq("decode branch", c.branch, branchD);
      expectEq("decode illegal", c.illegal, illegalInstrD);
      expectEq("decode rs1", w[19:15], rs1D);
      expectEq("decode rs2", w[24:20], rs2D);
    end

    ////////////////////////////// Pipelining
    for (int k = 0; k < 40; k++) begin
      case ($urandom_range(3, 0))
        0: w = encI(ctrlPkg::opLoad, pickReg(), 3'd2, pickReg());
        1: w = encS(pickReg(), pickReg(), 3'($urandom_range(2, 0)), pickReg());
        2: w = encU(ctrlPkg::opAuipc, pickReg());
        default: w = encR({1'b0, 1'($urandom), 5'd0}, pickReg(), pickReg(),
                          3'($urandom_range(7, 0)), pickReg());
      endcase
      hist.push_back(w);
    end
    repeat (3) hist.push_back('0);             // Drain words
    for (int k = 0; k < 43; k++) begin
      clockIn(hist[k]);
      #1;
      if (k >= 1) begin
        c = refCtrl(hist[k-1]);
        expectEq("pipe funct3E", hist[k-1][14:12], funct3E);
        expectEq("pipe memRWE", c.memRW, memRWE);
        expectEq("pipe rdE", hist[k-1][11:7], rdE);
        expectEq("pipe rs2E", hist[k-1][24:20], rs2E);
        expectEq("pipe validE", 1, instrValidE);
        expectEq("pipe aluSrcAE", c.aluSrcA, aluSrcAE);
        expectEq("pipe aluSrcBE", c.aluSrcB, aluSrcBE);
        expectEq("pipe aluSelectE", c.aluOp ? hist[k-1][14:12] : 3'd0, aluSelectE);
        expectEq("pipe subArithE", refSubArith(hist[k-1]), subArithE);
        expectEq("pipe mduActiveE", c.mdu, mduActiveE);
      end
      if (k >= 2) begin
        c = refCtrl(hist[k-2]);
        expectEq("pipe funct3M", hist[k-2][14:12], funct3M);
        expectEq("pipe memRWM", c.memRW, memRWM);
        expectEq("pipe rdM", hist[k-2][11:7], rdM);
        expectEq("pipe validM", 1, instrValidM);
      end
      if (k >= 3) begin
        c = refCtrl(hist[k-3]);
        expectEq("pipe rdW", hist[k-3][11:7], rdW);
        expectEq("pipe regWriteW", c.regWrite, regWriteW);
        expectEq("pipe resultSrcW", c.resultSrc, resultSrcW);
      end
    end

    // Held Execute stall
    w = encR(7'h00, 5'd2, 5'd1, 3'd6, 5'd9);
    clockIn(w);
    clockIn(encR(7'h00, 5'd4, 5'd3, 3'd1, 5'd11));
    stallE = 1'b1;
    clockIn('0);
    #1;
    expectEq("stall rdE", 9, rdE);
    expectEq("stall funct3E", 6, funct3E);
    stallE = 1'b0;

    // Flushes give bubbles
    clockIn(w);
    flushE = 1'b1;
    clockIn('0);
    #1;
    expectEq("flush validE", 0, instrValidE);
    expectEq("flush rdE", 0, rdE);
    flushE = 1'b0;
    clockIn(w);
    clockIn('0);
    clockIn('0);
    flushW = 1'b1;
    clockIn('0);
    #1;
    expectEq("flush regWriteW", 0, regWriteW);
    flushW = 1'b0;
    flushD = 1'b1;
    clockIn('0);
    #1;
    expectEq("flush validD", 0, instrValidD);
    flushD = 1'b0;

    ////////////////////////////// Branches
    for (int i = 0; i < 30; i++) begin
      do f3 = 3'($urandom_range(7, 0)); while (f3 == 3'd2 || f3 == 3'd3);
      clockIn(encB(pickReg(), pickReg(), f3));
      clockIn('0);                            // Branch now in Execute
      stallE = 1'b1;                          // Hold it over several flag values
      for (int j = 0; j < 4; j++) begin
        flagsE = 2'($urandom);
        #1;
        expTaken = (f3[2] ? flagsE[0] : flagsE[1]) ^ f3[0];
        expectEq("branch pcSrcE", expTaken, pcSrcE);
        expectEq("branch signed", !(f3 == 3'd6 || f3 == 3'd7), branchSignedE);
        clockIn('0);
      end
      stallE = 1'b0;
    end
    clockIn(encJ(pickReg()));
    clockIn('0);
    #1;
    expectEq("jal pcSrcE", 1, pcSrcE);

    ////////////////////////////// Forwarding
    r = pickReg();
    clockIn(encR(7'h00, 5'd1, 5'd1, 3'd0, r));
    clockIn(encR(7'h00, 5'd1, 5'd1, 3'd0, r));
    clockIn(encR(7'h00, 5'd0, r, 3'd0, 5'd1));
    clockIn('0);
    #1;
    expectEq("fwd mem priority", ctrlPkg::fwdMem, forwardAE);
    expectEq("fwd x0 source", ctrlPkg::fwdRf, forwardBE);
    clockIn(encR(7'h00, 5'd1, 5'd1, 3'd0, r));
    clockIn(encS(5'd1, 5'd1, 3'd2, r));     // Same rd field, no regWrite
    clockIn(encR(7'h00, r, r, 3'd0, 5'd1));
    clockIn('0);
    #1;
    expectEq("fwd wb A", ctrlPkg::fwdWb, forwardAE);
    expectEq("fwd wb B", ctrlPkg::fwdWb, forwardBE);
    clockIn(encR(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
    clockIn(encR(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
    clockIn(encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd1));
    clockIn('0);
    #1;
    expectEq("fwd x0 dest", ctrlPkg::fwdRf, forwardAE);

    ////////////////////////////// Stalls
    r = pickReg();
    r2 = pickReg();
    clockIn(encI(ctrlPkg::opLoad, 5'd1, 3'd2, r));
    clockIn(encR(7'h00, 5'd0, r, 3'd0, r2));
    #1;
    expectEq("load-use stall", 1, loadStallD);
    expectEq("load-use struct", 1, structuralStallD);
    clockIn(encS(r2, 5'd1, 3'd2, 5'd0));
    clockIn(encI(ctrlPkg::opLoad, 5'd2, 3'd2, 5'd3));
    #1;
    expectEq("store-load stall", 1, storeStallD);
    clockIn(encCsr(3'd1, 5'd1, r));
    clockIn(encR(7'h00, r, 5'd0, 3'd0, r2));
    #1;
    expectEq("csr-use struct", 1, structuralStallD);
    expectEq("csr-use load", 0, loadStallD);
    clockIn(encR(7'h01, 5'd1, 5'd2, 3'd0, r));   // mul
    clockIn(encR(7'h00, 5'd0, r, 3'd0, r2));
    #1;
    expectEq("mdu-use struct", 1, structuralStallD);
    clockIn(encI(ctrlPkg::opLoad, 5'd1, 3'd2, 5'd0));
    clockIn(encR(7'h00, 5'd0, 5'd0, 3'd0, r2));
    #1;
    expectEq("x0 load stall", 0, loadStallD);
    expectEq("x0 struct stall", 0, structuralStallD);

    ////////////////////////////// CSR write and divide
    for (int i = 0; i < 4; i++) begin
      f3 = (i == 0) ? 3'd2 : (i == 1) ? 3'd3 : (i == 2) ? 3'd1 : 3'd0;
      w = encCsr(f3, (i == 2) ? pickReg() : 5'd0, (i == 3) ? 5'd0 : pickReg());
      clockIn(w);
      clockIn('0);
      clockIn('0);
      #1;
      c = refCtrl(w);
      expectEq("csr write", (i == 2), csrWriteM);
      expectEq("csr read", c.csrRead, csrReadM);
      expectEq("csr privileged", c.privileged, privilegedM);
    end
    clockIn(encR(7'h01, 5'd2, 5'd1, 3'd4, r));   // div
    clockIn('0);
    #1;
    expectEq("div intDivE", 1, intDivE);
    expectEq("div mduActiveE", 1, mduActiveE);
    clockIn('0);
    clockIn('0);
    #1;
    expectEq("div intDivW", 1, intDivW);
    expectEq("div resultSrcW", ctrlPkg::resMdu, resultSrcW);

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- project.f
+incdir+bench
src/ctrlPkg.sv
src/instrDecoder.sv
src/stageReg.sv
src/executeCtrl.sv
src/hazardUnit.sv
src/controller.sv
bench/tbController.sv

//--- src/controller.sv
// Pipeline controller top for the five-stage RV32IM core, decode through writeback and hazards
module controller (
  input  logic               clk,
  input  logic               rstN,
  // Decode
  input  logic               stallD, flushD,
  input  ctrlPkg::instrT     instrD,
  output ctrlPkg::immSrcT    immSrcD,
  output logic               illegalInstrD,
  output logic               jumpD,
  output logic               branchD,
  output ctrlPkg::regAddrT   rs1D, rs2D,
  // Execute
  input  logic               stallE, flushE,
  input  logic [1:0]         flagsE,          // {equal, less-than}
  output ctrlPkg::regAddrT   rs2E, rdE,
  output logic               pcSrcE,
  output logic               aluSrcAE, aluSrcBE,
  output logic [2:0]         aluSelectE,
  output logic [2:0]         funct3E,
  output logic               subArithE,
  output logic               branchSignedE,
  output logic               intDivE,
  output logic               mduActiveE,
  output logic [1:0]         memRWE,
  // Memory
  input  logic               stallM, flushM,
  output ctrlPkg::regAddrT   rdM,
  output logic [1:0]         memRWM,
  output logic               csrReadM, csrWriteM, privilegedM,
  output logic [2:0]         funct3M,
  output logic               instrValidD, instrValidE, instrValidM,
  // Writeback
  input  logic               stallW, flushW,
  output logic               regWriteW, intDivW,
  output ctrlPkg::resultSrcT resultSrcW,
  output ctrlPkg::regAddrT   rdW,
  // Hazards
  output ctrlPkg::fwdSelT    forwardAE, forwardBE,
  output logic               loadStallD,
  output logic               storeStallD,
  output logic               structuralStallD
);

  ctrlPkg::ctrlWordT    ctrlD;
  ctrlPkg::regAddrT     rdD;
  logic [2:0]           aluSelectD, funct3D;
  logic                 subArithD, csrWriteD;
  ctrlPkg::execPayloadT execD, execE;
  ctrlPkg::memPayloadT  memE, memM;
  ctrlPkg::wbPayloadT   wbM, wbW;

  //////////////////////////////
  // Decode
  //////////////////////////////
  instrDecoder u_decoder (
    .instrD, .rs1D, .rs2D, .rdD, .ctrlD,
    .aluSelectD, .subArithD, .csrWriteD, .funct3D
  );

  assign immSrcD       = ctrlD.immSrc;
  assign illegalInstrD = ctrlD.illegal;
  assign jumpD         = ctrlD.jump;
  assign branchD       = ctrlD.branch;

  stageReg #(.payloadT(logic)) u_regD (
    .clk, .rstN, .flush(flushD), .en(~stallD), .d(1'b1), .q(instrValidD)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////
  assign execD = '{
    aluSelect:  aluSelectD,      regWrite: ctrlD.regWrite,
    resultSrc:  ctrlD.resultSrc, memRW:    ctrlD.memRW,
    jump:       ctrlD.jump,      branch:   ctrlD.branch,
    aluSrcA:    ctrlD.aluSrcA,   aluSrcB:  ctrlD.aluSrcB,
    csrRead:    ctrlD.csrRead,   csrWrite: csrWriteD,
    privileged: ctrlD.privileged, funct3:  funct3D,
    subArith:   subArithD,       mdu:      ctrlD.mdu,
    valid:      instrValidD,
    rs1:        rs1D, rs2: rs2D, rd: rdD
  };

  stageReg #(.payloadT(ctrlPkg::execPayloadT)) u_regE (
    .clk, .rstN, .flush(flushE), .en(~stallE), .d(execD), .q(execE)
  );

  assign rs2E        = execE.rs2;
  assign rdE         = execE.rd;
  assign aluSrcAE    = execE.aluSrcA;
  assign aluSrcBE    = execE.aluSrcB;
  assign aluSelectE  = execE.aluSelect;
  assign funct3E     = execE.funct3;
  assign subArithE   = execE.subArith;
  assign memRWE      = execE.memRW;
  assign instrValidE = execE.valid;

  executeCtrl u_execCtrl (
    .branchE(execE.branch), .jumpE(execE.jump), .mduE(execE.mdu),
    .funct3E(execE.funct3), .resultSrcE(execE.resultSrc), .flagsE,
    .pcSrcE, .branchSignedE, .intDivE, .mduActiveE
  );

  //////////////////////////////
  // Memory
  //////////////////////////////
  assign memE = '{
    regWrite:   execE.regWrite,   resultSrc: execE.resultSrc,
    memRW:      execE.memRW,      csrRead:   execE.csrRead,
    csrWrite:   execE.csrWrite,   privileged: execE.privileged,
    funct3:     execE.funct3,     intDiv:    intDivE,
    valid:      execE.valid,      rd:        execE.rd
  };

  stageReg #(.payloadT(ctrlPkg::memPayloadT)) u_regM (
    .clk, .rstN, .flush(flushM), .en(~stallM), .d(memE), .q(memM)
  );

  assign rdM         = memM.rd;
  assign memRWM      = memM.memRW;
  assign csrReadM    = memM.csrRead;
  assign csrWriteM   = memM.csrWrite;        // Also flushes younger stages outside
  assign privilegedM = memM.privileged;
  assign funct3M     = memM.funct3;
  assign instrValidM = memM.valid;

  //////////////////////////////
  // Writeback
  //////////////////////////////
  assign wbM = '{
    regWrite:  memM.regWrite,
    resultSrc: memM.resultSrc,
    intDiv:    memM.intDiv,
    rd:        memM.rd
  };

  stageReg #(.payloadT(ctrlPkg::wbPayloadT)) u_regW (
    .clk, .rstN, .flush(flushW), .en(~stallW), .d(wbM), .q(wbW)
  );

  assign regWriteW  = wbW.regWrite;
  assign resultSrcW = wbW.resultSrc;
  assign intDivW    = wbW.intDiv;
  assign rdW        = wbW.rd;

  //////////////////////////////
  // Hazards
  //////////////////////////////
  hazardUnit u_hazard (
    .rs1D, .rs2D, .rs1E(execE.rs1), .rs2E(execE.rs2), .rdE(execE.rd),
    .rdM(memM.rd), .rdW(wbW.rd),
    .memRWD(ctrlD.memRW), .memRWE(execE.memRW),
    .csrReadE(execE.csrRead), .mduE(execE.mdu),
    .regWriteM(memM.regWrite), .regWriteW(wbW.regWrite),
    .forwardAE, .forwardBE, .loadStallD, .storeStallD, .structuralStallD
  );

endmodule

//--- src/ctrlPkg.sv
// Pipeline controller package with opcodes, field widths, control encodings and stage payloads
package ctrlPkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////
  localparam int regAddrW = 5;                  // Register index
  localparam int instrW   = 32;                 // Instruction word
  localparam int opcodeW  = 7;                  // Major opcode
  localparam int funct3W  = 3;                  // funct3 field
  localparam int funct7W  = 7;                  // funct7 field

  typedef logic [regAddrW-1:0] regAddrT;
  typedef logic [instrW-1:0]   instrT;

  //////////////////////////////
  // Major opcodes (RV32IM + Zicsr)
  //////////////////////////////
  localparam logic [opcodeW-1:0] opLoad   = 7'b0000011;
  localparam logic [opcodeW-1:0] opFence  = 7'b0001111;  // Plain fence only, decodes as a no-op
  localparam logic [opcodeW-1:0] opOpImm  = 7'b0010011;
  localparam logic [opcodeW-1:0] opAuipc  = 7'b0010111;
  localparam logic [opcodeW-1:0] opStore  = 7'b0100011;
  localparam logic [opcodeW-1:0] opOp     = 7'b0110011;  // R-type and M-type
  localparam logic [opcodeW-1:0] opLui    = 7'b0110111;
  localparam logic [opcodeW-1:0] opBranch = 7'b1100011;
  localparam logic [opcodeW-1:0] opJalr   = 7'b1100111;
  localparam logic [opcodeW-1:0] opJal    = 7'b1101111;
  localparam logic [opcodeW-1:0] opSystem = 7'b1110011;  // CSR access and privileged ops

  //////////////////////////////
  // Control encodings
  //////////////////////////////
  typedef logic [2:0] immSrcT;
  localparam immSrcT immI = 3'd0;
  localparam immSrcT immS = 3'd1;
  localparam immSrcT immB = 3'd2;
  localparam immSrcT immJ = 3'd3;
  localparam immSrcT immU = 3'd4;

  typedef logic [2:0] resultSrcT;
  localparam resultSrcT resAlu = 3'd0;
  localparam resultSrcT resMem = 3'd1;
  localparam resultSrcT resCsr = 3'd2;
  localparam resultSrcT resMdu = 3'd3;

  typedef logic [1:0] fwdSelT;
  localparam fwdSelT fwdRf  = 2'd0;             // Register file operand
  localparam fwdSelT fwdWb  = 2'd1;             // Bypass from Writeback
  localparam fwdSelT fwdMem = 2'd2;             // Bypass from Memory

  localparam logic [funct3W-1:0] aluAdd = 3'b000; // Address generation select

  // Main decoder output, MSB first
  typedef struct packed {
    logic      regWrite;
    immSrcT    immSrc;
    logic      aluSrcA;                         // 1 selects PC
    logic      aluSrcB;                         // 1 selects immediate
    logic [1:0] memRW;                          // {read, write}
    resultSrcT resultSrc;
    logic      branch;
    logic      aluOp;                           // ALU function taken from funct3
    logic      jump;
    logic      csrRead;
    logic      privileged;
    logic      mdu;
    logic      illegal;
  } ctrlWordT;

  localparam ctrlWordT ctrlIllegal = '{default: '0, illegal: 1'b1};

  //////////////////////////////
  // Stage payloads
  //////////////////////////////
  typedef struct packed {
    logic [funct3W-1:0] aluSelect;
    logic      regWrite;
    resultSrcT resultSrc;
    logic [1:0] memRW;
    logic      jump;
    logic      branch;
    logic      aluSrcA;
    logic      aluSrcB;
    logic      csrRead;
    logic      csrWrite;
    logic      privileged;
    logic [funct3W-1:0] funct3;
    logic      subArith;
    logic      mdu;
    logic      valid;
    regAddrT   rs1;
    regAddrT   rs2;
    regAddrT   rd;
  } execPayloadT;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
    logic [1:0] memRW;
    logic      csrRead;
    logic      csrWrite;
    logic      privileged;
    logic [funct3W-1:0] funct3;
    logic      intDiv;
    logic      valid;
    regAddrT   rd;
  } memPayloadT;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
    logic      intDiv;
    regAddrT   rd;
  } wbPayloadT;

endpackage

//--- src/executeCtrl.sv
// Execute-stage branch resolution and derived MDU controls
module executeCtrl (
  input  logic               branchE,
  input  logic               jumpE,
  input  logic               mduE,
  input  logic [2:0]         funct3E,
  input  ctrlPkg::resultSrcT resultSrcE,
  input  logic [1:0]         flagsE,          // {equal, less-than}
  output logic               pcSrcE,
  output logic               branchSignedE,
  output logic               intDivE,
  output logic               mduActiveE
);

  logic eqE, ltE;
  logic branchFlagE;                          // Flag chosen by the condition
  logic takenE;

  assign eqE = flagsE[1];
  assign ltE = flagsE[0];

  //////////////////////////////
  // Branch resolution
  //////////////////////////////
  // beq/bne use eq, blt/bge/bltu/bgeu use lt, bit 0 inverts
  assign branchFlagE = funct3E[2] ? ltE : eqE;
  assign takenE      = branchFlagE ^ funct3E[0];
  assign pcSrcE      = jumpE | (branchE & takenE);

  // Comparator runs unsigned only for bltu and bgeu
  assign branchSignedE = branchE & (funct3E[2:1] != 2'b11);

  //////////////////////////////
  // MDU controls
  //////////////////////////////
  assign intDivE    = mduE & funct3E[2];      // div, divu, rem, remu
  assign mduActiveE = (resultSrcE == ctrlPkg::resMdu);

endmodule

//--- src/hazardUnit.sv
// Hazard unit with forwarding selects and structural stall detection
module hazardUnit (
  input  ctrlPkg::regAddrT rs1D, rs2D,
  input  ctrlPkg::regAddrT rs1E, rs2E, rdE,
  input  ctrlPkg::regAddrT rdM, rdW,
  input  logic [1:0]       memRWD,            // {read, write}
  input  logic [1:0]       memRWE,
  input  logic             csrReadE,
  input  logic             mduE,
  input  logic             regWriteM,
  input  logic             regWriteW,
  output ctrlPkg::fwdSelT  forwardAE, forwardBE,
  output logic             loadStallD,
  output logic             storeStallD,
  output logic             structuralStallD
);

  logic matchDE;                              // Decode source needs the Execute result
  logic csrRdStallD, mduStallD;

  // Newest producer wins, x0 never bypasses
  function automatic ctrlPkg::fwdSelT fwdSel(
    input ctrlPkg::regAddrT rs,
    input ctrlPkg::regAddrT rdMem,
    input ctrlPkg::regAddrT rdWb,
    input logic             wrMem,
    input logic             wrWb
  );
    ctrlPkg::fwdSelT sel;
    sel = ctrlPkg::fwdRf;
    if (rs != '0) begin
      if ((rs == rdMem) & wrMem)
        sel = ctrlPkg::fwdMem;
      else if ((rs == rdWb) & wrWb)
        sel = ctrlPkg::fwdWb;
    end
    return sel;
  endfunction

  //////////////////////////////
  // Forwarding
  //////////////////////////////
  assign forwardAE = fwdSel(rs1E, rdM, rdW, regWriteM, regWriteW);
  assign forwardBE = fwdSel(rs2E, rdM, rdW, regWriteM, regWriteW);

  //////////////////////////////
  // Structural stalls
  //////////////////////////////
  assign matchDE = ((rs1D == rdE) | (rs2D == rdE)) & (rdE != '0);

  assign loadStallD  = memRWE[1] & matchDE;   // Load data arrives in Memory
  assign storeStallD = memRWD[1] & memRWE[0]; // Load right behind a store
  assign csrRdStallD = csrReadE & matchDE;
  assign mduStallD   = mduE & matchDE;        // Multi-cycle result

  assign structuralStallD = loadStallD | storeStallD | csrRdStallD | mduStallD;

endmodule

//--- src/instrDecoder.sv
// Decode-stage instruction decoder with exact legality checks, ALU decode and CSR write qualify
module instrDecoder (
  input  ctrlPkg::instrT   instrD,
  output ctrlPkg::regAddrT rs1D, rs2D, rdD,
  output ctrlPkg::ctrlWordT ctrlD,
  output logic [2:0]       aluSelectD,
  output logic             subArithD,
  output logic             csrWriteD,
  output logic [2:0]       funct3D
);

  logic [ctrlPkg::opcodeW-1:0] opD;
  logic [ctrlPkg::funct7W-1:0] funct7D;
  ctrlPkg::ctrlWordT           word;          // Control word before legality override
  logic                        legal;
  logic funct7Zero, funct7Alt;                 // funct7 is 0x00 / 0x20
  logic shiftOk, rTypeOk, mTypeOk;
  logic loadOk, storeOk, branchOk;
  logic privOk, csrOk;
  logic subD, sraD, sltD, sltuD;
  logic csrZeroSrc;

  assign opD     = instrD[6:0];
  assign rdD     = instrD[11:7];
  assign funct3D = instrD[14:12];
  assign rs1D    = instrD[19:15];
  assign rs2D    = instrD[24:20];
  assign funct7D = instrD[31:25];

  //////////////////////////////
  // Field legality
  //////////////////////////////
  assign funct7Zero = (funct7D == 7'h00);
  assign funct7Alt  = (funct7D == 7'h20);
  // slli needs funct7 zero, srli/srai zero or 0x20, others free
  assign shiftOk  = (funct3D == 3'b001) ? funct7Zero :
                    (funct3D == 3'b101) ? (funct7Zero | funct7Alt) : 1'b1;
  assign rTypeOk  = funct7Zero | (funct7Alt & (funct3D == 3'b000 | funct3D == 3'b101));
  assign mTypeOk  = (funct7D == 7'h01);
  assign loadOk   = (funct3D == 3'b000) | (funct3D == 3'b001) | (funct3D == 3'b010) |
                    (funct3D == 3'b100) | (funct3D == 3'b101);   // lb lh lw lbu lhu
  assign storeOk  = (funct3D == 3'b000) | (funct3D == 3'b001) | (funct3D == 3'b010);
  assign branchOk = (funct3D[2:1] != 2'b01);                     // 010 and 011 reserved
  assign privOk   = (funct3D == 3'b000) & (rdD == '0);
  assign csrOk    = (funct3D[1:0] != 2'b00);

  //////////////////////////////
  // Main decoder
  //////////////////////////////
  always_comb begin
    word  = '0;
    legal = 1'b0;
    case (opD)
      ctrlPkg::opLoad: begin
        legal          = loadOk;
        word.regWrite  = 1'b1;
        word.aluSrcB   = 1'b1;
        word.memRW     = 2'b10;
        word.resultSrc = ctrlPkg::resMem;
      end
      ctrlPkg::opFence: legal = (funct3D == 3'b000);              // No-op
      ctrlPkg::opOpImm: begin
        legal         = shiftOk;
        word.regWrite = 1'b1;
        word.aluSrcB  = 1'b1;
        word.aluOp    = 1'b1;
      end
      ctrlPkg::opAuipc: begin
        legal         = 1'b1;
        word.regWrite = 1'b1;
        word.immSrc   = ctrlPkg::immU;
        word.aluSrcA  = 1'b1;
        word.aluSrcB  = 1'b1;
      end
      ctrlPkg::opStore: begin
        legal        = storeOk;
        word.immSrc  = ctrlPkg::immS;
        word.aluSrcB = 1'b1;
        word.memRW   = 2'b01;
      end
      ctrlPkg::opOp: begin
        legal         = rTypeOk | mTypeOk;
        word.regWrite = 1'b1;
        word.aluOp    = rTypeOk;
        word.mdu      = mTypeOk;
        if (mTypeOk)
          word.resultSrc = ctrlPkg::resMdu;
      end
      ctrlPkg::opLui: begin
        legal         = 1'b1;
        word.regWrite = 1'b1;
        word.immSrc   = ctrlPkg::immU;
        word.aluSrcB  = 1'b1;
      end
      ctrlPkg::opBranch: begin
        legal        = branchOk;
        word.immSrc  = ctrlPkg::immB;
        word.aluSrcA = 1'b1;                  // Target is PC + imm
        word.aluSrcB = 1'b1;
        word.branch  = 1'b1;
      end
      ctrlPkg::opJalr: begin
        legal         = (funct3D == 3'b000);
        word.regWrite = 1'b1;
        word.aluSrcB  = 1'b1;
        word.jump     = 1'b1;
      end
      ctrlPkg::opJal: begin
        legal         = 1'b1;
        word.regWrite = 1'b1;
        word.immSrc   = ctrlPkg::immJ;
        word.aluSrcA  = 1'b1;
        word.aluSrcB  = 1'b1;
        word.jump     = 1'b1;
      end
      ctrlPkg::opSystem: begin
        legal           = privOk | csrOk;
        word.privileged = privOk;             // ecall, ebreak, mret, wfi decoded later
        word.regWrite   = csrOk;
        word.csrRead    = csrOk;
        if (csrOk)
          word.resultSrc = ctrlPkg::resCsr;
      end
      default: legal = 1'b0;
    endcase
    ctrlD = legal ? word : ctrlPkg::ctrlIllegal;
  end

  //////////////////////////////
  // ALU and CSR decode
  //////////////////////////////
  assign aluSelectD = ctrlD.aluOp ? funct3D : ctrlPkg::aluAdd;   // Add for address generation
  assign subD       = (funct3D == 3'b000) & funct7D[5] & opD[5]; // opD[5] keeps addi out
  assign sraD       = (funct3D == 3'b101) & funct7D[5];
  assign sltD       = (funct3D == 3'b010);
  assign sltuD      = (funct3D == 3'b011);
  assign subArithD  = ctrlD.aluOp & (subD | sraD | sltD | sltuD);

  // csrrs/csrrc and immediate forms with zero source only read
  assign csrZeroSrc = (rs1D == '0);
  assign csrWriteD  = ctrlD.csrRead & ~(csrZeroSrc & funct3D[1]);

endmodule

//--- src/stageReg.sv
// Pipeline stage register with async reset, sync flush and enable, any payload type
module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    flush,                      // Wins over enable
  input  logic    en,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;                                // Bubble
    end else if (en) begin
      q <= d;
    end
  end

endmodule
